/* sources.f */
+incdir+src
src/minimig_pkg.sv
src/bus_req_if.sv
src/address_decoder.sv
src/request_queue.sv
src/memory_bridge.sv
src/minimig_bus.sv
testbench/tb_minimig_bus.sv

/* Bender.yml */
package:
  name: minimig_bus

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/minimig_pkg.sv
      - src/bus_req_if.sv
      - src/address_decoder.sv
      - src/request_queue.sv
      - src/memory_bridge.sv
      - src/minimig_bus.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_minimig_bus.sv

/* testbench/tb_minimig_bus.sv */
// testbench for the minimig cpu memory path
// random and directed cpu requests against a reference decoder and a
// shadow memory, responses checked in order, plus latency, overlay,
// clock chip and back-pressure runs

`include "minimig_settings.svh"

module tb_minimig_bus
	import minimig_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int N_RAND = 600;	// random mixed traffic
	localparam int N_SWEEP = 512;	// 16 configs x 32 blocks
	localparam int N_DIRECT = 100;	// upper bound for the directed phases
	localparam int N_REQ = N_RAND + N_SWEEP + N_DIRECT;
	localparam int MEM_WORDS = `BANK_COUNT * `BANK_WORDS;

	// one expected response
	typedef struct packed {
		data_t       data;
		logic        err;
		logic        check_data;	// off for never written words
		logic [31:0] cycle;	// acceptance cycle
	} exp_t;

	logic clk, reset, req_valid_i, req_ready_o, ovl_i;
	logic rsp_valid_o, rsp_ready_i, rsp_err_o;
	logic [`ADDR_W-1:0] req_addr_i;
	access_e req_access_i;
	byte_en_t req_be_i;
	data_t req_wdata_i, rsp_rdata_o;
	mem_config_t mem_config_i;
	logic [`RTC_W-1:0] rtc_i;

	exp_t exp_q [$];
	data_t shadow [MEM_WORDS];	// reference ram
	logic known [MEM_WORDS];	// word fully written once
	int unsigned cycle_cnt = 0;
	logic ready_rand;	// random rsp_ready_i
	logic lat_mode;	// check 3 cycle latency

	minimig_bus dut0 (.*);

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic void decode_ref(input logic [23:0] a, input access_e acc,
		input mem_config_t cfg, input logic ovl, output region_e r, output bank_t b);
		logic [1:0] j;
		r = REGION_NONE;
		b = '0;
		j = 2'((a - `SLOW_BASE) >> 19);	// slow block index
		if (a < 24'h200000) begin
			if (ovl && acc == ACCESS_READ && a[20:19] == 2'd0) begin
				r = REGION_KICK;	// overlay maps rom at 0
				b = 3'd7;
			end else if (a[20:19] <= cfg.chip_size) begin
				r = REGION_CHIP;
				b = bank_t'(a[20:19]);
			end
		end else if (a >= `SLOW_BASE && a < `SLOW_BASE + 24'h180000) begin
			if (j < cfg.slow_size) begin
				r = REGION_SLOW;
				b = 3'd4 + bank_t'(j);
			end
		end else if (a >= `KICK_BASE) begin
			if (acc == ACCESS_READ || ovl) begin
				r = REGION_KICK;
				b = 3'd7;
			end
		end else if (a[23:16] == 8'hDC) begin
			r = REGION_RTC;
		end
	endfunction

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// accepted request -> expected response
	task automatic model_accept();
		logic [23:0] a;
		logic [11:0] idx;
		region_e r;
		bank_t b;
		exp_t e;
		a = {req_addr_i, 1'b0};
		decode_ref(a, req_access_i, mem_config_i, ovl_i, r, b);
		idx = {b, a[9:1]};	// word offset aliases in block
		e = '{data: '0, err: 1'b0, check_data: 1'b1, cycle: cycle_cnt};
		if (r == REGION_NONE) begin
			e.err = 1'b1;
		end else if (r == REGION_RTC) begin
			if (req_access_i == ACCESS_READ) e.data = data_t'(rtc_i[a[5:2] * 4 +: 4]);
		end else if (req_access_i == ACCESS_WRITE) begin
			if (req_be_i[0]) shadow[idx][7:0] = req_wdata_i[7:0];
			if (req_be_i[1]) shadow[idx][15:8] = req_wdata_i[15:8];
			known[idx] = known[idx] || req_be_i == 2'b11;
		end else begin
			e.data = shadow[idx];
			e.check_data = known[idx];
		end
		exp_q.push_back(e);
	endtask

	task automatic check_response();
		exp_t e;
		assert (exp_q.size() != 0) else begin
			$display("a response arrived with no request outstanding");
			abort_run();
		end
		e = exp_q.pop_front();
		assert (rsp_err_o === e.err) else begin
			$display("Fail rsp_err_o expected %h got %h", e.err, rsp_err_o);
			abort_run();
		end
		assert (!e.check_data || rsp_rdata_o === e.data) else begin
			$display("Fail rsp_rdata_o expected %h got %h", e.data, rsp_rdata_o);
			abort_run();
		end
		assert (!lat_mode || cycle_cnt - e.cycle == 3) else begin
			$display("Fail rsp_valid_o latency expected %h got %h", 3, cycle_cnt - e.cycle);
			abort_run();
		end
	endtask

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	// holds the request until accepted and returns 2 ns after that edge
	task automatic send_req(input logic [23:0] a, input access_e acc, input byte_en_t be,
		input data_t wd);
		req_valid_i = 1'b1;
		req_addr_i = a[23:1];
		req_access_i = acc;
		req_be_i = be;
		req_wdata_i = wd;
		@(posedge clk);
		while (!req_ready_o) @(posedge clk);
		#2 req_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		@(posedge clk);
		while (exp_q.size() != 0) @(posedge clk);
		#2;
	endtask

	// low word bits kept small so reads hit earlier writes
	function automatic logic [23:0] rand_addr();
		logic [23:0] field;
		field = (24'($urandom) & 24'h07FC00) | 24'($urandom_range(0, 15) << 1);
		case ($urandom_range(0, 4))
			0: return (24'($urandom_range(0, 3)) << 19) | field;	// chip
			1: return `SLOW_BASE + ((24'($urandom_range(0, 2)) << 19) | field);
			2: return `KICK_BASE | field;
			3: return `RTC_BASE | (24'($urandom) & 24'h00FFFE);
			default: return 24'($urandom) & 24'hFFFFFE;	// anywhere
		endcase
	endfunction

	// ------------------------------
	// clock, ready, monitor, watchdog
	// ------------------------------
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		#2 rsp_ready_i = ready_rand ? ($urandom_range(0, 3) != 0) : 1'b1;
	end

	always @(posedge clk) begin
		if (!reset) begin
			if (rsp_valid_o && rsp_ready_i) check_response();
			if (req_valid_i && req_ready_o) model_accept();
		end
		cycle_cnt++;
	end

	initial begin
		#(20 * N_REQ * CLK_PERIOD);
		$display("timeout, the run did not finish in time");
		abort_run();
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		void'($urandom(32'h36b0a17a));
		{req_valid_i, req_addr_i, req_be_i, req_wdata_i, ovl_i} = '0;
		req_access_i = ACCESS_READ;
		mem_config_i = '0;
		rtc_i = {$urandom, $urandom};	// constant for the run
		rsp_ready_i = 1'b1;
		ready_rand = 1'b0;
		lat_mode = 1'b0;
		reset = 1'b1;
		foreach (known[i]) known[i] = 1'b0;
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		assert (req_ready_o === 1'b1) else begin
			$display("Fail req_ready_o expected %h got %h", 1'b1, req_ready_o);
			abort_run();
		end
		assert (rsp_valid_o === 1'b0) else begin
			$display("Fail rsp_valid_o expected %h got %h", 1'b0, rsp_valid_o);
			abort_run();
		end

		// random traffic, random configs and back-pressure
		ready_rand = 1'b1;
		repeat (N_RAND) begin
			mem_config_i = mem_config_t'($urandom);
			ovl_i = $urandom_range(0, 3) == 0;
			send_req(rand_addr(), access_e'($urandom_range(0, 1)), byte_en_t'($urandom),
				data_t'($urandom));
			repeat ($urandom_range(0, 2)) begin
				@(posedge clk);	// request gap
				#2;
			end
		end
		ready_rand = 1'b0;
		wait_drain();

		// byte lanes on one chip word
		mem_config_i = 4'hF;
		ovl_i = 1'b0;
		send_req(24'h000100, ACCESS_WRITE, 2'b11, 16'h1234);
		send_req(24'h000100, ACCESS_WRITE, 2'b10, 16'hABCD);	// upper only
		send_req(24'h000100, ACCESS_WRITE, 2'b01, 16'h5566);	// lower only
		send_req(24'h000100, ACCESS_READ, 2'b11, '0);

		// load rom under the overlay then read it through chip block 0
		ovl_i = 1'b1;
		for (int i = 0; i < 8; i++) send_req(`KICK_BASE + 24'(i * 2), ACCESS_WRITE, 2'b11,
			16'hA500 + data_t'(i));
		for (int i = 0; i < 8; i++) send_req(24'(i * 2), ACCESS_READ, 2'b11, '0);
		for (int i = 0; i < 8; i++) send_req(24'(i * 2), ACCESS_WRITE, 2'b11,
			16'h5A00 + data_t'(i));	// lands in bank 0
		ovl_i = 1'b0;
		for (int i = 0; i < 8; i++) send_req(24'(i * 2), ACCESS_READ, 2'b11, '0);
		for (int i = 0; i < 4; i++) send_req(`KICK_BASE + 24'(i * 2), ACCESS_WRITE, 2'b11,
			16'hDEAD);	// unmapped without overlay
		for (int i = 0; i < 8; i++) send_req(`KICK_BASE + 24'(i * 2), ACCESS_READ, 2'b11, '0);

		// clock chip nibbles
		for (int i = 0; i < 16; i++) send_req(`RTC_BASE + 24'(i * 4), ACCESS_READ, 2'b11, '0);
		send_req(`RTC_BASE, ACCESS_WRITE, 2'b11, 16'hFFFF);

		// single requests with exact latency
		wait_drain();
		lat_mode = 1'b1;
		repeat (8) begin
			send_req(rand_addr(), access_e'($urandom_range(0, 1)), 2'b11, data_t'($urandom));
			wait_drain();
		end
		lat_mode = 1'b0;

		// every block start under every config
		for (int c = 0; c < 16; c++) begin
			mem_config_i = mem_config_t'(c);
			for (int blk = 0; blk < 32; blk++) send_req(24'(blk << 19), ACCESS_READ, 2'b11, '0);
		end
		wait_drain();

		// pipeline empty once the last response is taken
		assert (rsp_valid_o === 1'b0) else begin
			$display("Fail rsp_valid_o expected %h got %h", 1'b0, rsp_valid_o);
			abort_run();
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* src/minimig_bus.sv */
// minimig cpu memory path, top level
// cpu request -> address decoder -> request queue -> ram bridge
// -> response, all in request order with valid/ready on both ends
// three cycles from acceptance to response without back-pressure

`include "minimig_settings.svh"

module minimig_bus
	import minimig_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	// cpu request
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  logic [`ADDR_W-1:0] req_addr_i,	// word address 23..1
	input  access_e           req_access_i,
	input  byte_en_t          req_be_i,	// {uds, lds}
	input  data_t             req_wdata_i,
	// configuration, sampled at decode
	input  mem_config_t       mem_config_i,
	input  logic              ovl_i,
	// clock chip, sampled at the bridge
	input  logic [`RTC_W-1:0] rtc_i,
	// response
	output logic              rsp_valid_o,
	input  logic              rsp_ready_i,
	output data_t             rsp_rdata_o,
	output logic              rsp_err_o
);

	bus_req_if dec_q ();	// decoder -> queue
	bus_req_if q_br ();	// queue -> bridge

	// ------------------------------
	// pipeline
	// ------------------------------
	address_decoder dec0 (
		.clk          (clk),
		.reset        (reset),
		.req_valid_i  (req_valid_i),
		.req_ready_o  (req_ready_o),
		.req_addr_i   (req_addr_i),
		.req_access_i (req_access_i),
		.req_be_i     (req_be_i),
		.req_wdata_i  (req_wdata_i),
		.mem_config_i (mem_config_i),
		.ovl_i        (ovl_i),
		.out          (dec_q.producer)
	);

	request_queue #(
		.DEPTH (`REQ_QUEUE_DEPTH)
	) queue0 (
		.clk   (clk),
		.reset (reset),
		.in    (dec_q.consumer),
		.out   (q_br.producer)
	);

	memory_bridge bridge0 (
		.clk         (clk),
		.reset       (reset),
		.in          (q_br.consumer),
		.rtc_i       (rtc_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_rdata_o (rsp_rdata_o),
		.rsp_err_o   (rsp_err_o)
	);

endmodule

/* src/memory_bridge.sv */
// on-chip ram bridge
// eight 512-word banks addressed by bank and offset, byte-lane
// writes, clock chip nibble reads and a response register that
// holds read data or the unmapped error until it is taken

`include "minimig_settings.svh"

module memory_bridge
	import minimig_pkg::*;
(
	input  logic             clk,
	input  logic             reset,
	bus_req_if.consumer      in,
	input  logic [`RTC_W-1:0] rtc_i,	// clock chip registers
	output logic             rsp_valid_o,
	input  logic             rsp_ready_i,
	output data_t            rsp_rdata_o,
	output logic             rsp_err_o
);

	localparam int RAM_WORDS = `BANK_COUNT * `BANK_WORDS;
	localparam int LANES = `DATA_W / 8;

	data_t ram [RAM_WORDS];	// all banks back to back
	logic [$clog2(RAM_WORDS)-1:0] ram_addr;
	logic [3:0] rtc_nib;
	logic take;
	logic ram_region;
	logic is_read;
	logic ram_we;

	// ------------------------------
	// request side
	// ------------------------------
	assign in.ready = !rsp_valid_o || rsp_ready_i;	// response slot free
	assign take = in.valid && in.ready;

	assign ram_addr = {in.bank, in.offset};
	assign ram_region = in.region inside {REGION_CHIP, REGION_SLOW, REGION_KICK};
	assign is_read = in.access == ACCESS_READ;
	assign ram_we = take && ram_region && !is_read;
	assign rtc_nib = rtc_i[{in.rtc_sel, 2'b00} +: 4];	// addr 5..2 picks nibble

	// byte lane writes
	always_ff @(posedge clk) begin
		if (ram_we) begin
			for (int l = 0; l < LANES; l++) begin
				if (in.be[l]) begin
					ram[ram_addr][l*8 +: 8] <= in.wdata[l*8 +: 8];
				end
			end
		end
	end

	// ------------------------------
	// response register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid_o <= 1'b0;
		end else if (take) begin
			rsp_valid_o <= 1'b1;
		end else if (rsp_ready_i) begin
			rsp_valid_o <= 1'b0;	// taken
		end
	end

	// read data and error, loaded on take only
	always_ff @(posedge clk) begin
		if (take) begin
			rsp_err_o <= in.region == REGION_NONE;
			unique case (in.region)
				REGION_CHIP, REGION_SLOW, REGION_KICK: begin
					rsp_rdata_o <= is_read ? ram[ram_addr] : '0;	// old word on read
				end
				REGION_RTC: begin
					rsp_rdata_o <= is_read ? data_t'(rtc_nib) : '0;	// writes ignored
				end
				default: begin
					rsp_rdata_o <= '0;	// unmapped
				end
			endcase
		end
	end

endmodule

/* src/request_queue.sv */
// decoded request FIFO
// circular buffer between decoder and memory bridge, push and pop
// in the same cycle, head entry presented directly from storage

`include "minimig_settings.svh"

module request_queue
	import minimig_pkg::*;
#(
	parameter int DEPTH = `REQ_QUEUE_DEPTH	// power of two
) (
	input  logic        clk,
	input  logic        reset,
	bus_req_if.consumer in,
	bus_req_if.producer out
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// one stored request
	typedef struct packed {
		region_e  region;
		bank_t    bank;
		offset_t  offset;
		access_e  access;
		byte_en_t be;
		data_t    wdata;
		rtc_sel_t rtc_sel;
	} item_t;

	item_t mem [DEPTH];	// payload storage, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;	// 0..DEPTH
	logic push;
	logic pop;

	// ------------------------------
	// handshakes
	// ------------------------------
	assign in.ready = count != (PTR_W + 1)'(DEPTH);	// not full
	assign out.valid = count != '0;
	assign push = in.valid && in.ready;
	assign pop = out.valid && out.ready;

	// head of queue
	assign out.region = mem[rd_ptr].region;
	assign out.bank = mem[rd_ptr].bank;
	assign out.offset = mem[rd_ptr].offset;
	assign out.access = mem[rd_ptr].access;
	assign out.be = mem[rd_ptr].be;
	assign out.wdata = mem[rd_ptr].wdata;
	assign out.rtc_sel = mem[rd_ptr].rtc_sel;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= '{in.region, in.bank, in.offset, in.access,
				in.be, in.wdata, in.rtc_sel};
		end
	end

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			unique case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// idle or both
			endcase
		end
	end

endmodule

/* src/address_decoder.sv */
// cpu address decoder and bank mapper
// classifies a cpu request into chip, slow, kick, rtc or unmapped
// under the memory configuration and the kickstart overlay, picks
// the ram bank and word offset and holds the result in one output slot

`include "minimig_settings.svh"

module address_decoder
	import minimig_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  logic [`ADDR_W-1:0] req_addr_i,	// word address 23..1
	input  access_e           req_access_i,
	input  byte_en_t          req_be_i,
	input  data_t             req_wdata_i,
	input  mem_config_t       mem_config_i,
	input  logic              ovl_i,	// kickstart overlay
	bus_req_if.producer       out
);

	localparam int BLK_W = `ADDR_W + 1 - `BLOCK_BITS;	// 512K block tag width
	localparam int RTC_TAG_W = `ADDR_W + 1 - `RTC_BITS;
	localparam logic [BLK_W-1:0] SLOW_TAG = BLK_W'(`SLOW_BASE >> `BLOCK_BITS);
	localparam logic [BLK_W-1:0] KICK_TAG = BLK_W'(`KICK_BASE >> `BLOCK_BITS);
	localparam logic [RTC_TAG_W-1:0] RTC_TAG = RTC_TAG_W'(`RTC_BASE >> `RTC_BITS);
	localparam bank_t KICK_BANK = bank_t'(`BANK_COUNT - 1);	// last bank holds rom
	localparam bank_t SLOW_BANK0 = bank_t'(`CHIP_BLOCKS);	// slow follows chip

	logic [`ADDR_W:0] byte_addr;	// full byte address, bit 0 always 0
	logic [BLK_W-1:0] blk;	// 512K block number
	logic [BLK_W-1:0] slow_idx;	// block relative to slow base
	logic chip_hit;
	logic slow_hit;
	logic kick_hit;
	logic rtc_hit;
	logic is_read;
	logic accept;
	region_e d_region;
	bank_t d_bank;

	assign byte_addr = {req_addr_i, 1'b0};
	assign blk = byte_addr[`ADDR_W:`BLOCK_BITS];
	assign slow_idx = blk - SLOW_TAG;	// wraps high below the base

	// ------------------------------
	// window hits
	// ------------------------------
	assign chip_hit = blk < `CHIP_BLOCKS;
	assign slow_hit = slow_idx < `SLOW_BLOCKS;
	assign kick_hit = blk == KICK_TAG;
	assign rtc_hit = byte_addr[`ADDR_W:`RTC_BITS] == RTC_TAG;
	assign is_read = req_access_i == ACCESS_READ;

	// region and bank
	always_comb begin
		d_region = REGION_NONE;	// default unmapped
		d_bank = '0;
		if (chip_hit) begin
			if (ovl_i && is_read && blk == '0) begin
				d_region = REGION_KICK;	// overlay, reads see rom
				d_bank = KICK_BANK;
			end else if (blk[1:0] <= mem_config_i.chip_size) begin
				d_region = REGION_CHIP;
				d_bank = bank_t'(blk[1:0]);
			end
		end else if (slow_hit) begin
			if (slow_idx[1:0] < mem_config_i.slow_size) begin
				d_region = REGION_SLOW;
				d_bank = SLOW_BANK0 + bank_t'(slow_idx[1:0]);
			end
		end else if (kick_hit) begin
			// rom is writable only while the overlay is up (loading)
			if (is_read || ovl_i) begin
				d_region = REGION_KICK;
				d_bank = KICK_BANK;
			end
		end else if (rtc_hit) begin
			d_region = REGION_RTC;
		end
	end

	// ------------------------------
	// output slot
	// ------------------------------
	assign req_ready_o = !out.valid || out.ready;	// empty or draining
	assign accept = req_valid_i && req_ready_o;

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (accept) begin
			out.valid <= 1'b1;
		end else if (out.ready) begin
			out.valid <= 1'b0;	// taken, nothing new
		end
	end

	// payload, loaded only on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			out.region <= d_region;
			out.bank <= d_bank;
			out.offset <= offset_t'(req_addr_i);	// low word bits, aliased
			out.access <= req_access_i;
			out.be <= req_be_i;
			out.wdata <= req_wdata_i;
			out.rtc_sel <= byte_addr[2 +: $bits(rtc_sel_t)];	// addr 5..2
		end
	end

endmodule

/* src/bus_req_if.sv */
// decoded memory request channel
// one request per valid/ready handshake, payload held stable
// from valid until the transfer

interface bus_req_if
	import minimig_pkg::*;
();

	logic     valid;
	logic     ready;
	region_e  region;
	bank_t    bank;
	offset_t  offset;
	access_e  access;
	byte_en_t be;
	data_t    wdata;
	rtc_sel_t rtc_sel;	// only meaningful for REGION_RTC

	// request source
	modport producer (
		output valid, region, bank, offset, access, be, wdata, rtc_sel,
		input  ready
	);

	// request sink
	modport consumer (
		input  valid, region, bank, offset, access, be, wdata, rtc_sel,
		output ready
	);

endinterface

/* src/minimig_pkg.sv */
// minimig memory path types
// region and access encodings plus the bank, offset, data and
// memory configuration types shared by decoder, queue and bridge

`include "minimig_settings.svh"

package minimig_pkg;

	// ------------------------------
	// encodings
	// ------------------------------

	// where a decoded access lands
	typedef enum logic [2:0] {
		REGION_CHIP,	// chip ram, banks 0..3
		REGION_SLOW,	// slow ram, banks 4..6
		REGION_KICK,	// kickstart, bank 7
		REGION_RTC,	// clock chip nibbles
		REGION_NONE	// unmapped, error response
	} region_e;

	typedef enum logic {
		ACCESS_READ,
		ACCESS_WRITE
	} access_e;

	// ------------------------------
	// payload types
	// ------------------------------
	typedef logic [$clog2(`BANK_COUNT)-1:0] bank_t;	// 3 bits
	typedef logic [$clog2(`BANK_WORDS)-1:0] offset_t;	// 9 bits, addr 9..1
	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`DATA_W/8-1:0] byte_en_t;	// bit 1 = upper byte (uds)
	typedef logic [$clog2(`RTC_W/4)-1:0] rtc_sel_t;	// nibble index, addr 5..2

	// memory configuration as seen on the cpu side
	// chip_size 0=512K .. 3=2M, slow_size 0=none .. 3=1.5M
	typedef struct packed {
		logic [1:0] slow_size;	// upper bits
		logic [1:0] chip_size;	// lower bits
	} mem_config_t;

endpackage

/* src/minimig_settings.svh */
// minimig memory path settings
// bus widths, bank geometry, queue depth and the address windows
// that the decoder maps onto the eight on-chip RAM banks

`ifndef MINIMIG_SETTINGS_SVH
`define MINIMIG_SETTINGS_SVH

// ------------------------------
// bus widths
// ------------------------------
`define ADDR_W 23              // cpu word address, bits 23..1
`define DATA_W 16              // cpu data bus
`define RTC_W 64               // clock chip register image

// ------------------------------
// ram geometry
// ------------------------------
`define BANK_COUNT 8           // chip 0..3, slow 4..6, kick 7
`define BANK_WORDS 512         // offset aliases inside each 512K block
`define REQ_QUEUE_DEPTH 4      // decoded requests waiting for the bridge

// ------------------------------
// address windows (byte addresses)
// ------------------------------
`define BLOCK_BITS 19          // 512K block select starts at byte bit 19
`define CHIP_BLOCKS 4          // 0x000000..0x1fffff
`define SLOW_BASE 24'hC00000   // slow ram start
`define SLOW_BLOCKS 3          // up to 1.5M
`define KICK_BASE 24'hF80000   // 512K kickstart window
`define RTC_BASE 24'hDC0000    // clock chip
`define RTC_BITS 16            // 64K rtc window

`endif
